// File: include/opcodes.svh
`ifndef OPCODES_SVH
`define OPCODES_SVH

// primary opcodes, instr[31:26]
`define OP_RTYPE  6'b000000
`define OP_REGIMM 6'b000001
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_BLEZ   6'b000110
`define OP_BGTZ   6'b000111
`define OP_ADDIU  6'b001001
`define OP_SLTI   6'b001010
`define OP_SLTIU  6'b001011
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_XORI   6'b001110
`define OP_LUI    6'b001111
`define OP_COP0   6'b010000
`define OP_LB     6'b100000
`define OP_LH     6'b100001
`define OP_LW     6'b100011
`define OP_LBU    6'b100100
`define OP_LHU    6'b100101
`define OP_SB     6'b101000
`define OP_SH     6'b101001
`define OP_SW     6'b101011

// R-type funct field, instr[5:0]
`define FN_SLL    6'b000000
`define FN_SRL    6'b000010
`define FN_SRA    6'b000011
`define FN_SLLV   6'b000100
`define FN_SRLV   6'b000110
`define FN_SRAV   6'b000111
`define FN_JR     6'b001000
`define FN_JALR   6'b001001
`define FN_ADDU   6'b100001
`define FN_SUBU   6'b100011
`define FN_AND    6'b100100
`define FN_OR     6'b100101
`define FN_XOR    6'b100110
`define FN_NOR    6'b100111
`define FN_SLT    6'b101010
`define FN_SLTU   6'b101011

// REGIMM branches are told apart by rt
`define RT_BLTZ   5'b00000
`define RT_BGEZ   5'b00001

`endif

// File: design/ctlPkg.sv
package ctlPkg;

   typedef logic [5:0]  opcodeT;
   typedef logic [5:0]  functT;
   typedef logic [4:0]  regAddrT;
   typedef logic [31:0] wordT;
   typedef logic [3:0]  byteEnT;
   // top nibble of an address
   typedef logic [3:0]  regionT;
   typedef logic [1:0]  memSizeT;
   typedef logic [3:0]  aluOpT;

   localparam memSizeT MEM_BYTE = 2'd0;
   localparam memSizeT MEM_HALF = 2'd1;
   localparam memSizeT MEM_WORD = 2'd2;

   // add is zero so an all-zero decode is harmless
   localparam aluOpT ALU_ADD  = 4'd0;
   localparam aluOpT ALU_SUB  = 4'd1;
   localparam aluOpT ALU_AND  = 4'd2;
   localparam aluOpT ALU_OR   = 4'd3;
   localparam aluOpT ALU_XOR  = 4'd4;
   localparam aluOpT ALU_NOR  = 4'd5;
   localparam aluOpT ALU_SLT  = 4'd6;
   localparam aluOpT ALU_SLTU = 4'd7;
   localparam aluOpT ALU_SLL  = 4'd8;
   localparam aluOpT ALU_SRL  = 4'd9;
   localparam aluOpT ALU_SRA  = 4'd10;
   localparam aluOpT ALU_LUI  = 4'd11;

   typedef struct packed {
      logic    memToReg;
      logic    regWrite;
      logic    extType;
      logic    aluSrc;
      logic    regDst;
      logic    jump;
      logic    jr;
      logic    jal;
      logic    jalr;
      logic    shift;
      logic    isLoad;
      logic    isStore;
      memSizeT memSize;
      aluOpT   aluOp;
      logic    mtc0;
      logic    mfc0;
      logic    delaySlot;
   } decodeCtlT;

   typedef struct packed {
      logic fwdAfromMtoE;
      logic fwdBfromMtoE;
      logic fwdAfromMtoF;
      logic fwdBfromMtoF;
      logic loadUseStall;
   } fwdCtlT;

   // execute-stage view: decoded bits plus the register fields
   typedef struct packed {
      decodeCtlT ctl;
      opcodeT    opcodeE;
      regAddrT   rsE;
      regAddrT   rtE;
      regAddrT   waE;
      logic      valid;
   } execCtlT;

endpackage

// File: design/mainDecoder.sv
`include "opcodes.svh"

module mainDecoder (
   input  ctlPkg::opcodeT    opcodeF,
   input  ctlPkg::functT     functF,
   input  ctlPkg::regAddrT   rsF,
   output ctlPkg::decodeCtlT decodeF
);

   always_comb begin
      decodeF = '0;
      case (opcodeF)
         `OP_RTYPE: begin
            decodeF.regWrite = (functF != `FN_JR);
            decodeF.regDst   = 1'b1;
            decodeF.jr       = (functF == `FN_JR);
            decodeF.jalr     = (functF == `FN_JALR);
            decodeF.shift    = (functF == `FN_SLL) || (functF == `FN_SRL) ||
                               (functF == `FN_SRA);
            decodeF.delaySlot = (functF == `FN_JR) || (functF == `FN_JALR);
            case (functF)
               `FN_SUBU:           decodeF.aluOp = ctlPkg::ALU_SUB;
               `FN_AND:            decodeF.aluOp = ctlPkg::ALU_AND;
               `FN_OR:             decodeF.aluOp = ctlPkg::ALU_OR;
               `FN_XOR:            decodeF.aluOp = ctlPkg::ALU_XOR;
               `FN_NOR:            decodeF.aluOp = ctlPkg::ALU_NOR;
               `FN_SLT:            decodeF.aluOp = ctlPkg::ALU_SLT;
               `FN_SLTU:           decodeF.aluOp = ctlPkg::ALU_SLTU;
               `FN_SLL, `FN_SLLV:  decodeF.aluOp = ctlPkg::ALU_SLL;
               `FN_SRL, `FN_SRLV:  decodeF.aluOp = ctlPkg::ALU_SRL;
               `FN_SRA, `FN_SRAV:  decodeF.aluOp = ctlPkg::ALU_SRA;
               // addu, jr, jalr
               default:            decodeF.aluOp = ctlPkg::ALU_ADD;
            endcase
         end
         `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
            decodeF.memToReg = 1'b1;
            decodeF.regWrite = 1'b1;
            decodeF.aluSrc   = 1'b1;
            decodeF.isLoad   = 1'b1;
            decodeF.aluOp    = ctlPkg::ALU_ADD;
            if (opcodeF == `OP_LW) begin
               decodeF.memSize = ctlPkg::MEM_WORD;
            end else if (opcodeF == `OP_LH || opcodeF == `OP_LHU) begin
               decodeF.memSize = ctlPkg::MEM_HALF;
            end else begin
               decodeF.memSize = ctlPkg::MEM_BYTE;
            end
         end
         `OP_SB, `OP_SH, `OP_SW: begin
            // memToReg set on stores as well, the write path ignores it
            decodeF.memToReg = 1'b1;
            decodeF.aluSrc   = 1'b1;
            decodeF.isStore  = 1'b1;
            decodeF.aluOp    = ctlPkg::ALU_ADD;
            case (opcodeF)
               `OP_SW:  decodeF.memSize = ctlPkg::MEM_WORD;
               `OP_SH:  decodeF.memSize = ctlPkg::MEM_HALF;
               default: decodeF.memSize = ctlPkg::MEM_BYTE;
            endcase
         end
         `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_LUI: begin
            decodeF.regWrite = 1'b1;
            decodeF.aluSrc   = 1'b1;
            case (opcodeF)
               `OP_SLTI:  decodeF.aluOp = ctlPkg::ALU_SLT;
               `OP_SLTIU: decodeF.aluOp = ctlPkg::ALU_SLTU;
               `OP_LUI:   decodeF.aluOp = ctlPkg::ALU_LUI;
               default:   decodeF.aluOp = ctlPkg::ALU_ADD;
            endcase
         end
         `OP_ANDI, `OP_ORI, `OP_XORI: begin
            // logical immediates are zero extended
            decodeF.regWrite = 1'b1;
            decodeF.extType  = 1'b1;
            decodeF.aluSrc   = 1'b1;
            case (opcodeF)
               `OP_ANDI: decodeF.aluOp = ctlPkg::ALU_AND;
               `OP_ORI:  decodeF.aluOp = ctlPkg::ALU_OR;
               default:  decodeF.aluOp = ctlPkg::ALU_XOR;
            endcase
         end
         `OP_J: begin
            decodeF.jump      = 1'b1;
            decodeF.delaySlot = 1'b1;
         end
         `OP_JAL: begin
            decodeF.regWrite  = 1'b1;
            decodeF.regDst    = 1'b1;
            decodeF.jump      = 1'b1;
            decodeF.jal       = 1'b1;
            decodeF.delaySlot = 1'b1;
         end
         `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM: begin
            // resolved in execute, only the delay slot matters here
            decodeF.aluOp     = ctlPkg::ALU_SUB;
            decodeF.delaySlot = 1'b1;
         end
         `OP_COP0: begin
            if (rsF == 5'd0) begin
               decodeF.regWrite  = 1'b1;
               decodeF.mfc0      = 1'b1;
               decodeF.delaySlot = 1'b1;
            end else if (rsF == 5'd4) begin
               decodeF.mtc0      = 1'b1;
               decodeF.delaySlot = 1'b1;
            end
         end
         default: decodeF = '0;
      endcase
   end

endmodule

// File: design/hazardCtl.sv
module hazardCtl (
   input  ctlPkg::regAddrT rsF,
   input  ctlPkg::regAddrT rtF,
   input  ctlPkg::execCtlT ctlE,
   input  ctlPkg::regAddrT waM,
   input  logic            regWriteM,
   output ctlPkg::fwdCtlT  fwd
);

   logic mWrites;
   logic eLoads;

   // r0 is never a real destination
   assign mWrites = regWriteM && (waM != 5'd0);

   // load sitting in execute whose data is not yet back
   assign eLoads = ctlE.valid && ctlE.ctl.isLoad && (ctlE.waE != 5'd0);

   // M result into the execute operands
   assign fwd.fwdAfromMtoE = mWrites && (waM == ctlE.rsE);
   assign fwd.fwdBfromMtoE = mWrites && (waM == ctlE.rtE);

   // M result into the fetch-stage register read
   assign fwd.fwdAfromMtoF = mWrites && (waM == rsF);
   assign fwd.fwdBfromMtoF = mWrites && (waM == rtF);

   // dependent instruction right behind a load has to wait one cycle
   assign fwd.loadUseStall = eLoads && ((ctlE.waE == rsF) || (ctlE.waE == rtF));

endmodule

// File: design/ctlPipeReg.sv
module ctlPipeReg (
   input  logic              clk,
   input  logic              arstN,
   input  logic              stall,
   input  ctlPkg::decodeCtlT decodeF,
   input  logic              loadUseStall,
   input  ctlPkg::opcodeT    opcodeF,
   input  ctlPkg::regAddrT   rsF,
   input  ctlPkg::regAddrT   rtF,
   input  ctlPkg::regAddrT   rdF,
   output ctlPkg::execCtlT   ctlE
);

   ctlPkg::execCtlT nextE;

   // what execute sees if the fetch instruction moves on
   always_comb begin
      nextE.ctl     = decodeF;
      nextE.opcodeE = opcodeF;
      nextE.rsE     = rsF;
      nextE.rtE     = rtF;
      nextE.valid   = 1'b1;
      // jal links into r31
      if (decodeF.jal) begin
         nextE.waE = 5'd31;
      end else if (decodeF.regDst) begin
         nextE.waE = rdF;
      end else begin
         nextE.waE = rtF;
      end
   end

   // hold beats bubble, bubble beats capture
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         ctlE <= '0;
      end else if (stall) begin
         ctlE <= ctlE;
      end else if (loadUseStall) begin
         ctlE <= '0;
      end else begin
         ctlE <= nextE;
      end
   end

   // an invalid execute word never writes the register file or memory
   bubbleIsInert: assert property (
      @(posedge clk) disable iff (!arstN)
      !ctlE.valid |-> (!ctlE.ctl.regWrite && !ctlE.ctl.isStore)
   ) else $error("invalid execute stage carries regWrite or isStore");

endmodule

// File: design/execCtl.sv
`include "opcodes.svh"

module execCtl #(
   parameter ctlPkg::regionT DMEM_REGION = 4'd1,
   parameter ctlPkg::regionT IMEM_REGION = 4'd2,
   parameter ctlPkg::wordT   IO_BASE     = 32'h8000_0000
) (
   input  ctlPkg::execCtlT ctlE,
   input  ctlPkg::wordT    aluOutE,
   input  ctlPkg::wordT    rd1Fwd,
   input  ctlPkg::wordT    rd2Fwd,
   output logic            branchTaken,
   output ctlPkg::byteEnT  dataMemWriteEn,
   output ctlPkg::byteEnT  instrMemWriteEn,
   output logic            legalReadE,
   output logic [3:0]      ioSel
);

   ctlPkg::regionT region;
   ctlPkg::byteEnT laneMask;
   ctlPkg::byteEnT storeMask;
   logic           loadE;
   logic           condMet;

   assign region = aluOutE[31:28];
   assign loadE  = ctlE.valid && ctlE.ctl.isLoad;

   // branch condition on the forwarded operands
   always_comb begin
      case (ctlE.opcodeE)
         `OP_BEQ:  condMet = (rd1Fwd == rd2Fwd);
         `OP_BNE:  condMet = (rd1Fwd != rd2Fwd);
         `OP_BLEZ: condMet = ($signed(rd1Fwd) <= 0);
         `OP_BGTZ: condMet = ($signed(rd1Fwd) > 0);
         `OP_REGIMM: begin
            if (ctlE.rtE == `RT_BLTZ) begin
               condMet = rd1Fwd[31];
            end else if (ctlE.rtE == `RT_BGEZ) begin
               condMet = !rd1Fwd[31];
            end else begin
               condMet = 1'b0;
            end
         end
         default:  condMet = 1'b0;
      endcase
   end

   assign branchTaken = ctlE.valid && condMet;

   // byte lanes touched by the store
   always_comb begin
      case (ctlE.ctl.memSize)
         ctlPkg::MEM_BYTE: laneMask = 4'b0001 << aluOutE[1:0];
         ctlPkg::MEM_HALF: laneMask = aluOutE[1] ? 4'b1100 : 4'b0011;
         ctlPkg::MEM_WORD: laneMask = 4'b1111;
         default:          laneMask = 4'b0000;
      endcase
   end

   assign storeMask = (ctlE.valid && ctlE.ctl.isStore) ? laneMask : 4'b0000;

   // route by address region
   assign dataMemWriteEn  = (region == DMEM_REGION) ? storeMask : 4'b0000;
   assign instrMemWriteEn = (region == IMEM_REGION) ? storeMask : 4'b0000;

   // readable regions: data cache, region 3, BIOS and IO
   always_comb begin
      case (region)
         4'h1, 4'h3, 4'h4, 4'h8: legalReadE = loadE;
         default:                legalReadE = 1'b0;
      endcase
   end

   // memory-mapped counters
   assign ioSel[0] = loadE && (aluOutE == IO_BASE + 32'h10);
   assign ioSel[1] = loadE && (aluOutE == IO_BASE + 32'h14);
   assign ioSel[2] = loadE && (aluOutE == IO_BASE + 32'h18);
   assign ioSel[3] = loadE && (aluOutE == IO_BASE + 32'h1C);

   // a store lands in at most one memory, also catches overlapping regions
   always_comb begin
      assert final (!((dataMemWriteEn != 4'b0000) && (instrMemWriteEn != 4'b0000)))
         else $error("store enables both data and instruction memory");
   end

endmodule

// File: design/ctlUnit.sv
module ctlUnit #(
   parameter ctlPkg::regionT DMEM_REGION = 4'd1,
   parameter ctlPkg::regionT IMEM_REGION = 4'd2,
   parameter ctlPkg::wordT   IO_BASE     = 32'h8000_0000
) (
   input  logic              clk,
   input  logic              arstN,
   input  logic              stall,
   input  ctlPkg::opcodeT    opcodeF,
   input  ctlPkg::functT     functF,
   input  ctlPkg::regAddrT   rsF,
   input  ctlPkg::regAddrT   rtF,
   input  ctlPkg::regAddrT   rdF,
   input  ctlPkg::regAddrT   waM,
   input  logic              regWriteM,
   input  ctlPkg::wordT      aluOutE,
   input  ctlPkg::wordT      rd1Fwd,
   input  ctlPkg::wordT      rd2Fwd,
   output ctlPkg::decodeCtlT decodeF,
   output ctlPkg::fwdCtlT    fwd,
   output ctlPkg::execCtlT   ctlE,
   output logic              branchTaken,
   output ctlPkg::byteEnT    dataMemWriteEn,
   output ctlPkg::byteEnT    instrMemWriteEn,
   output logic              legalReadE,
   output logic [3:0]        ioSel
);

   // fetch side, decode and hazard checks in parallel
   mainDecoder uDecoder (
      .opcodeF (opcodeF),
      .functF  (functF),
      .rsF     (rsF),
      .decodeF (decodeF)
   );

   hazardCtl uHazard (
      .rsF       (rsF),
      .rtF       (rtF),
      .ctlE      (ctlE),
      .waM       (waM),
      .regWriteM (regWriteM),
      .fwd       (fwd)
   );

   ctlPipeReg uPipe (
      .clk          (clk),
      .arstN        (arstN),
      .stall        (stall),
      .decodeF      (decodeF),
      .loadUseStall (fwd.loadUseStall),
      .opcodeF      (opcodeF),
      .rsF          (rsF),
      .rtF          (rtF),
      .rdF          (rdF),
      .ctlE         (ctlE)
   );

   // execute side
   execCtl #(
      .DMEM_REGION (DMEM_REGION),
      .IMEM_REGION (IMEM_REGION),
      .IO_BASE     (IO_BASE)
   ) uExec (
      .ctlE            (ctlE),
      .aluOutE         (aluOutE),
      .rd1Fwd          (rd1Fwd),
      .rd2Fwd          (rd2Fwd),
      .branchTaken     (branchTaken),
      .dataMemWriteEn  (dataMemWriteEn),
      .instrMemWriteEn (instrMemWriteEn),
      .legalReadE      (legalReadE),
      .ioSel           (ioSel)
   );

endmodule

// File: tb/ctlUnitTb.sv
`include "opcodes.svh"

module ctlUnitTb;

   localparam int RESET_CYCLES  = 16;
   localparam int RANDOM_CYCLES = 2000;
   // random and directed phases plus headroom
   localparam int CYCLE_LIMIT   = RANDOM_CYCLES * 3 / 2;
   localparam ctlPkg::regionT DMEM_REGION = 4'd1;
   localparam ctlPkg::regionT IMEM_REGION = 4'd2;
   localparam ctlPkg::wordT   IO_BASE     = 32'h8000_0000;

   typedef struct packed {
      logic           branchTaken;
      ctlPkg::byteEnT dataMemWriteEn;
      ctlPkg::byteEnT instrMemWriteEn;
      logic           legalReadE;
      logic [3:0]     ioSel;
   } execOutT;

   logic              clk;
   logic              arstN;
   logic              stall;
   logic              regWriteM;
   ctlPkg::opcodeT    opcodeF;
   ctlPkg::functT     functF;
   ctlPkg::regAddrT   rsF;
   ctlPkg::regAddrT   rtF;
   ctlPkg::regAddrT   rdF;
   ctlPkg::regAddrT   waM;
   ctlPkg::wordT      aluOutE;
   ctlPkg::wordT      rd1Fwd;
   ctlPkg::wordT      rd2Fwd;
   ctlPkg::decodeCtlT decodeF;
   ctlPkg::fwdCtlT    fwd;
   ctlPkg::execCtlT   ctlE;
   logic              branchTaken;
   ctlPkg::byteEnT    dataMemWriteEn;
   ctlPkg::byteEnT    instrMemWriteEn;
   logic              legalReadE;
   logic [3:0]        ioSel;

   ctlPkg::execCtlT   refE;
   ctlPkg::execCtlT   held;
   ctlPkg::decodeCtlT expDec;
   ctlPkg::fwdCtlT    expFwd;
   execOutT           expOut;
   integer            seed;
   int                cycleCount = 0;
   int                mismatchCount = 0;
   int                otherCount = 0;
   int                checkCount = 0;

   // legal opcodes followed by a few unused ones
   ctlPkg::opcodeT opTable [0:27] = '{`OP_RTYPE, `OP_REGIMM, `OP_J, `OP_JAL, `OP_BEQ,
      `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI,
      `OP_XORI, `OP_LUI, `OP_COP0, `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB,
      `OP_SH, `OP_SW, 6'h08, 6'h1c, 6'h2e, 6'h3f};
   ctlPkg::functT fnTable [0:15] = '{`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV,
      `FN_SRAV, `FN_JR, `FN_JALR, `FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
      `FN_SLT, `FN_SLTU};
   ctlPkg::regionT regionTable [0:4] = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h8};
   ctlPkg::opcodeT brOps [0:5] = '{`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM,
      `OP_REGIMM};
   ctlPkg::regAddrT brRt [0:5] = '{5'd2, 5'd2, 5'd0, 5'd0, `RT_BLTZ, `RT_BGEZ};
   ctlPkg::opcodeT stOps [0:2] = '{`OP_SB, `OP_SH, `OP_SW};

   ctlUnit dut (.*);

   function automatic ctlPkg::decodeCtlT decodeModel(ctlPkg::opcodeT op, ctlPkg::functT fn,
                                                     ctlPkg::regAddrT rs);
      ctlPkg::decodeCtlT d;
      logic isR;
      logic isLd;
      logic isSt;
      logic isArith;
      logic isLogic;
      logic isBr;
      d = '0;
      isR     = (op == `OP_RTYPE);
      isLd    = op inside {`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU};
      isSt    = op inside {`OP_SB, `OP_SH, `OP_SW};
      isArith = op inside {`OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_LUI};
      isLogic = op inside {`OP_ANDI, `OP_ORI, `OP_XORI};
      isBr    = op inside {`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM};
      d.mfc0     = (op == `OP_COP0) && (rs == 5'd0);
      d.mtc0     = (op == `OP_COP0) && (rs == 5'd4);
      d.jump     = (op == `OP_J) || (op == `OP_JAL);
      d.jal      = (op == `OP_JAL);
      d.jr       = isR && (fn == `FN_JR);
      d.jalr     = isR && (fn == `FN_JALR);
      d.shift    = isR && (fn inside {`FN_SLL, `FN_SRL, `FN_SRA});
      d.regDst   = isR || d.jal;
      d.regWrite = (isR && !d.jr) || isLd || isArith || isLogic || d.jal || d.mfc0;
      d.memToReg = isLd || isSt;
      d.aluSrc   = isLd || isSt || isArith || isLogic;
      d.extType  = isLogic;
      d.isLoad   = isLd;
      d.isStore  = isSt;
      d.delaySlot = isBr || d.jump || d.jr || d.jalr || d.mfc0 || d.mtc0;
      if (op == `OP_LW || op == `OP_SW) begin
         d.memSize = ctlPkg::MEM_WORD;
      end else if (op inside {`OP_LH, `OP_LHU, `OP_SH}) begin
         d.memSize = ctlPkg::MEM_HALF;
      end
      if (isR) begin
         case (fn)
            `FN_SUBU: d.aluOp = ctlPkg::ALU_SUB;
            `FN_AND:  d.aluOp = ctlPkg::ALU_AND;
            `FN_OR:   d.aluOp = ctlPkg::ALU_OR;
            `FN_XOR:  d.aluOp = ctlPkg::ALU_XOR;
            `FN_NOR:  d.aluOp = ctlPkg::ALU_NOR;
            `FN_SLT:  d.aluOp = ctlPkg::ALU_SLT;
            `FN_SLTU: d.aluOp = ctlPkg::ALU_SLTU;
            `FN_SLL, `FN_SLLV: d.aluOp = ctlPkg::ALU_SLL;
            `FN_SRL, `FN_SRLV: d.aluOp = ctlPkg::ALU_SRL;
            `FN_SRA, `FN_SRAV: d.aluOp = ctlPkg::ALU_SRA;
            default:  d.aluOp = ctlPkg::ALU_ADD;
         endcase
      end else if (isBr) begin
         d.aluOp = ctlPkg::ALU_SUB;
      end else begin
         case (op)
            `OP_SLTI:  d.aluOp = ctlPkg::ALU_SLT;
            `OP_SLTIU: d.aluOp = ctlPkg::ALU_SLTU;
            `OP_LUI:   d.aluOp = ctlPkg::ALU_LUI;
            `OP_ANDI:  d.aluOp = ctlPkg::ALU_AND;
            `OP_ORI:   d.aluOp = ctlPkg::ALU_OR;
            `OP_XORI:  d.aluOp = ctlPkg::ALU_XOR;
            default:   d.aluOp = ctlPkg::ALU_ADD;
         endcase
      end
      return d;
   endfunction

   function automatic ctlPkg::fwdCtlT hazardModel(ctlPkg::regAddrT rs, ctlPkg::regAddrT rt,
                                                  ctlPkg::execCtlT e, ctlPkg::regAddrT wa,
                                                  logic wr);
      ctlPkg::fwdCtlT f;
      logic mLive;
      mLive = wr && (wa != 5'd0);
      f.fwdAfromMtoE = mLive && (wa == e.rsE);
      f.fwdBfromMtoE = mLive && (wa == e.rtE);
      f.fwdAfromMtoF = mLive && (wa == rs);
      f.fwdBfromMtoF = mLive && (wa == rt);
      f.loadUseStall = e.valid && e.ctl.isLoad && (e.waE != 5'd0) &&
                       ((e.waE == rs) || (e.waE == rt));
      return f;
   endfunction

   function automatic ctlPkg::execCtlT pipeRegModel(ctlPkg::execCtlT cur, logic hold,
      logic lus, ctlPkg::decodeCtlT d, ctlPkg::opcodeT op, ctlPkg::regAddrT rs,
      ctlPkg::regAddrT rt, ctlPkg::regAddrT rd);
      ctlPkg::execCtlT n;
      n = '0;
      if (hold) begin
         n = cur;
      end else if (!lus) begin
         n.ctl     = d;
         n.opcodeE = op;
         n.rsE     = rs;
         n.rtE     = rt;
         n.waE     = d.jal ? 5'd31 : (d.regDst ? rd : rt);
         n.valid   = 1'b1;
      end
      return n;
   endfunction

   function automatic execOutT execModel(ctlPkg::execCtlT e, ctlPkg::wordT addr,
                                         ctlPkg::wordT a, ctlPkg::wordT b);
      execOutT o;
      ctlPkg::byteEnT mask;
      logic ld;
      o = '0;
      mask = 4'h0;
      ld = e.valid && e.ctl.isLoad;
      if (e.valid) begin
         case (e.opcodeE)
            `OP_BEQ:    o.branchTaken = (a == b);
            `OP_BNE:    o.branchTaken = (a != b);
            `OP_BLEZ:   o.branchTaken = a[31] || (a == 32'd0);
            `OP_BGTZ:   o.branchTaken = !a[31] && (a != 32'd0);
            `OP_REGIMM: o.branchTaken = (e.rtE == `RT_BLTZ) ? a[31] :
                                        ((e.rtE == `RT_BGEZ) && !a[31]);
            default:    o.branchTaken = 1'b0;
         endcase
      end
      if (e.valid && e.ctl.isStore) begin
         // each lane enabled by size and offset
         for (int k = 0; k < 4; k++) begin
            case (e.ctl.memSize)
               ctlPkg::MEM_BYTE: mask[k] = (2'(k) == addr[1:0]);
               ctlPkg::MEM_HALF: mask[k] = ((k >= 2) == addr[1]);
               ctlPkg::MEM_WORD: mask[k] = 1'b1;
               default:          mask[k] = 1'b0;
            endcase
         end
      end
      o.dataMemWriteEn  = (addr[31:28] == DMEM_REGION) ? mask : 4'h0;
      o.instrMemWriteEn = (addr[31:28] == IMEM_REGION) ? mask : 4'h0;
      o.legalReadE = ld && (addr[31:28] inside {4'h1, 4'h3, 4'h4, 4'h8});
      for (int k = 0; k < 4; k++) begin
         o.ioSel[k] = ld && (addr == IO_BASE + 32'h10 + 32'(4 * k));
      end
      return o;
   endfunction

   always_comb begin
      expDec = decodeModel(opcodeF, functF, rsF);
      expFwd = hazardModel(rsF, rtF, refE, waM, regWriteM);
      expOut = execModel(refE, aluOutE, rd1Fwd, rd2Fwd);
   end

   // model of the execute-stage control register
   always @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         refE <= '0;
      end else begin
         refE <= pipeRegModel(refE, stall, expFwd.loadUseStall, expDec, opcodeF, rsF, rtF,
                              rdF);
      end
   end

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      checkCount++;
      assert (got === exp) else begin
         mismatchCount++;
         $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // outputs settle between edges
   always @(negedge clk) begin
      if (cycleCount > 0) begin
         compare("decodeF", 64'(decodeF), 64'(expDec));
         compare("fwd", 64'(fwd), 64'(expFwd));
         compare("ctlE", 64'(ctlE), 64'(refE));
         compare("branchTaken", 64'(branchTaken), 64'(expOut.branchTaken));
         compare("dataMemWriteEn", 64'(dataMemWriteEn), 64'(expOut.dataMemWriteEn));
         compare("instrMemWriteEn", 64'(instrMemWriteEn), 64'(expOut.instrMemWriteEn));
         compare("legalReadE", 64'(legalReadE), 64'(expOut.legalReadE));
         compare("ioSel", 64'(ioSel), 64'(expOut.ioSel));
      end
   end

   task automatic randomExec;
      integer r;
      ctlPkg::wordT opA;
      r = $random(seed);
      opA = $random(seed);
      case (r[2:0])
         3'd5, 3'd6: aluOutE <= IO_BASE + 32'h10 + 32'({r[4:3], 2'b00});
         3'd7:       aluOutE <= $random(seed);
         default:    aluOutE <= {regionTable[r[2:0]], r[31:4]};
      endcase
      rd1Fwd <= (r[8:7] == 2'd0) ? 32'd0 : opA;
      rd2Fwd <= r[6] ? opA : $random(seed);
   endtask

   task automatic driveRandom(input logic holdStall);
      integer r;
      integer f;
      logic [4:0] idx;
      @(posedge clk);
      r = $random(seed);
      f = $random(seed);
      idx = 5'($unsigned(r) % 28);
      opcodeF   <= opTable[idx];
      functF    <= f[8] ? f[14:9] : fnTable[f[12:9]];
      // small register numbers so hazards actually happen
      rsF       <= {2'b00, f[17:15]};
      rtF       <= {2'b00, f[20:18]};
      rdF       <= {2'b00, f[23:21]};
      waM       <= {2'b00, f[26:24]};
      regWriteM <= f[27];
      stall     <= holdStall || (f[31:29] == 3'd0);
      randomExec();
   endtask

   task automatic driveInstr(input ctlPkg::opcodeT op, input ctlPkg::functT fn,
                             input ctlPkg::regAddrT rs, input ctlPkg::regAddrT rt,
                             input ctlPkg::regAddrT rd);
      @(posedge clk);
      opcodeF   <= op;
      functF    <= fn;
      rsF       <= rs;
      rtF       <= rt;
      rdF       <= rd;
      waM       <= 5'd0;
      regWriteM <= 1'b0;
      stall     <= 1'b0;
      randomExec();
   endtask

   task automatic printCounts;
      $display("checks %0d, mismatches %0d, other errors %0d",
               checkCount, mismatchCount, otherCount);
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
   end

   initial begin
      wait (cycleCount >= CYCLE_LIMIT);
      otherCount++;
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      printCounts();
      $display("sim failed");
      $finish;
   end

   initial begin
      seed      = 32'hda9b_04f2;
      arstN     = 1'b0;
      stall     = 1'b0;
      opcodeF   = '0;
      functF    = '0;
      rsF       = '0;
      rtF       = '0;
      rdF       = '0;
      waM       = '0;
      regWriteM = 1'b0;
      aluOutE   = '0;
      rd1Fwd    = '0;
      rd2Fwd    = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      arstN <= 1'b1;
      @(negedge clk);
      assert ((ctlE == '0) && !branchTaken && (dataMemWriteEn == 4'h0) &&
              (instrMemWriteEn == 4'h0) && !legalReadE && (ioSel == 4'h0)) else begin
         otherCount++;
         $display("execute stage is not cleared after reset");
      end

      repeat (RANDOM_CYCLES) driveRandom(1'b0);

      // r0 as M destination never forwards
      repeat (4) begin
         driveInstr(`OP_RTYPE, `FN_ADDU, 5'd0, 5'd0, 5'd0);
         regWriteM <= 1'b1;
      end

      // load then a dependent add
      driveInstr(`OP_LW, 6'd0, 5'd2, 5'd5, 5'd0);
      driveInstr(`OP_RTYPE, `FN_ADDU, 5'd5, 5'd3, 5'd6);
      @(negedge clk);
      assert (fwd.loadUseStall) else begin
         otherCount++;
         $display("dependent instruction after a load did not raise the load-use stall");
      end
      driveInstr(`OP_RTYPE, `FN_ADDU, 5'd5, 5'd3, 5'd6);
      @(negedge clk);
      assert (!ctlE.valid) else begin
         otherCount++;
         $display("no bubble entered execute after the load-use stall");
      end

      // hold the execute stage for a dozen cycles
      driveInstr(`OP_ORI, 6'd0, 5'd1, 5'd7, 5'd0);
      driveRandom(1'b1);
      @(negedge clk);
      held = ctlE;
      repeat (12) begin
         driveRandom(1'b1);
         @(negedge clk);
         assert (ctlE == held) else begin
            otherCount++;
            $display("execute stage changed while stall was held high");
         end
      end

      for (int i = 0; i < 36; i++) begin
         driveInstr(brOps[i % 6], 6'd0, 5'd1, brRt[i % 6], 5'd0);
      end

      // every size and offset into both writable regions
      for (int i = 0; i < 24; i++) begin
         driveInstr(stOps[i % 3], 6'd0, 5'd1, 5'd2, 5'd0);
         driveInstr(`OP_RTYPE, `FN_ADDU, 5'd0, 5'd0, 5'd0);
         aluOutE <= {(i < 12) ? DMEM_REGION : IMEM_REGION, 26'h0, 2'(i / 3 % 4)};
      end

      @(posedge clk);
      @(negedge clk);
      printCounts();
      if (mismatchCount + otherCount == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: src.f
+incdir+include
design/ctlPkg.sv
design/mainDecoder.sv
design/hazardCtl.sv
design/ctlPipeReg.sv
design/execCtl.sv
design/ctlUnit.sv
tb/ctlUnitTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module ctlUnitTb -o ctlUnitSim \
   > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/ctlUnitSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "sim failed" sim.log; then
   exit 1
fi
exit 0
